/* filelist.f */
src/bertPkg.sv
src/bertRegs.sv
src/pnGenerator.sv
src/streamRouter.sv
src/bertChecker.sv
src/bertTop.sv
tb/tbClock.sv
tb/bertTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module bertTb -f filelist.f -o simBert

./obj_dir/simBert | tee sim.log

if grep -q "Simulation passed" sim.log; then
    echo "run.sh: pass message found in sim.log"
    exit 0
else
    echo "run.sh: pass message missing from sim.log"
    exit 1
fi

/* src/bertChecker.sv */
`default_nettype none

module bertChecker (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           bertEnable,
    input  logic                           bertClkEn,
    input  logic                           bertData,
    input  logic                           countClear,
    input  logic [1:0]                     polySel,
    output logic                           locked,
    output logic [bertPkg::CountWidth-1:0] bitCount,
    output logic [bertPkg::CountWidth-1:0] errCount
);
    import bertPkg::*;

    logic [PnMaxLen-1:0]       history;
    logic                      bitEn;
    logic                      mismatch;
    logic [MatchCntWidth-1:0]  matchRun;
    logic [WindowCntWidth-1:0] winBits;
    logic [WinErrWidth-1:0]    winErrs;

    assign bitEn = bertEnable && bertClkEn;

    // Self-synchronizing prediction from the received bits
    assign mismatch = pnPredict(polySel, history) ^ bertData;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            history <= '0;
        end else if (bitEn) begin
            history <= {history[PnMaxLen-2:0], bertData};
        end
    end

    //**********************************************************
    // Lock detection
    //**********************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            locked   <= 1'b0;
            matchRun <= '0;
            winBits  <= '0;
            winErrs  <= '0;
        end else if (bitEn) begin
            if (!locked) begin
                // Run of consecutive matches
                if (mismatch) begin
                    matchRun <= '0;
                end else if (matchRun == MatchCntWidth'(LockMatchCount - 1)) begin
                    locked   <= 1'b1;
                    matchRun <= '0;
                    winBits  <= '0;
                    winErrs  <= '0;
                end else begin
                    matchRun <= matchRun + 1'b1;
                end
            end else begin
                // Fixed windows of UnlockWindow bits
                if (mismatch && (winErrs == WinErrWidth'(UnlockErrors - 1))) begin
                    locked  <= 1'b0;
                    winBits <= '0;
                    winErrs <= '0;
                end else if (winBits == WindowCntWidth'(UnlockWindow - 1)) begin
                    winBits <= '0;
                    winErrs <= '0;
                end else begin
                    winBits <= winBits + 1'b1;
                    winErrs <= winErrs + WinErrWidth'(mismatch);
                end
            end
        end
    end

    //**********************************************************
    // Bit and error counters
    //**********************************************************
    // Registered lock keeps the locking bit out of the count
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bitCount <= '0;
            errCount <= '0;
        end else if (countClear) begin
            bitCount <= '0;
            errCount <= '0;
        end else if (bitEn && locked) begin
            if (bitCount != '1) begin
                bitCount <= bitCount + 1'b1;
            end
            if (mismatch && (errCount != '1)) begin
                errCount <= errCount + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) errCount <= bitCount)
        else $error("Error count above bit count");

endmodule

`default_nettype wire

/* src/bertPkg.sv */
`default_nettype none

package bertPkg;

    //**********************************************************
    // Host register bus
    //**********************************************************
    localparam int DataWidth = 16;
    localparam int AddrWidth = 4;

    // Word addresses
    localparam logic [AddrWidth-1:0] AddrVersion    = 4'd0;
    localparam logic [AddrWidth-1:0] AddrControl    = 4'd1;
    localparam logic [AddrWidth-1:0] AddrRate       = 4'd2;
    localparam logic [AddrWidth-1:0] AddrStatus     = 4'd3;
    localparam logic [AddrWidth-1:0] AddrBitCountLo = 4'd4;
    localparam logic [AddrWidth-1:0] AddrBitCountHi = 4'd5;
    localparam logic [AddrWidth-1:0] AddrErrCountLo = 4'd6;
    localparam logic [AddrWidth-1:0] AddrErrCountHi = 4'd7;
    localparam logic [AddrWidth-1:0] AddrInject     = 4'd8;

    localparam logic [DataWidth-1:0] VersionNumber = 16'd428;

    //**********************************************************
    // PN polynomials
    //**********************************************************
    localparam logic [1:0] PolyPn7  = 2'd0;
    localparam logic [1:0] PolyPn15 = 2'd1;
    localparam logic [1:0] PolyPn23 = 2'd2;

    localparam int PnMaxLen = 23;

    // Tap positions, same numbering as the exponents
    localparam int Pn7TapA  = 7;
    localparam int Pn7TapB  = 6;
    localparam int Pn15TapA = 15;
    localparam int Pn15TapB = 14;
    localparam int Pn23TapA = 23;
    localparam int Pn23TapB = 18;

    // Stream sources, codes 2 to 7 idle
    localparam logic [2:0] SrcPnGen    = 3'd0;
    localparam logic [2:0] SrcExternal = 3'd1;

    //**********************************************************
    // BERT lock detection and counters
    //**********************************************************
    localparam int LockMatchCount = 32;
    localparam int UnlockWindow   = 64;
    localparam int UnlockErrors   = 8;
    localparam int MatchCntWidth  = $clog2(LockMatchCount);
    localparam int WindowCntWidth = $clog2(UnlockWindow);
    localparam int WinErrWidth    = $clog2(UnlockErrors);
    localparam int CountWidth     = 32;

    // Control register, written raw and read back as fields
    typedef union packed {
        logic [DataWidth-1:0] raw;
        struct packed {
            logic [4:0] spareHi;
            logic [2:0] outSource;
            logic       spare7;
            logic [2:0] bertSource;
            logic [1:0] polySel;
            logic       bertEnable;
            logic       pnEnable;
        } fields;
    } ctrlWordU;

    // Next PN bit from a history with the newest bit in [0]
    function automatic logic pnPredict(
        input logic [1:0]          poly,
        input logic [PnMaxLen-1:0] hist
    );
        logic nextBit;
        case (poly)
            PolyPn7:  nextBit = hist[Pn7TapA-1] ^ hist[Pn7TapB-1];
            PolyPn15: nextBit = hist[Pn15TapA-1] ^ hist[Pn15TapB-1];
            default:  nextBit = hist[Pn23TapA-1] ^ hist[Pn23TapB-1];
        endcase
        return nextBit;
    endfunction

endpackage

`default_nettype wire

/* src/bertRegs.sv */
`default_nettype none

module bertRegs (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           busWr,
    input  logic                           busRd,
    input  logic [bertPkg::AddrWidth-1:0]  busAddr,
    input  logic [bertPkg::DataWidth-1:0]  busWrData,
    output logic [bertPkg::DataWidth-1:0]  busRdData,
    output logic                           pnEnable,
    output logic                           bertEnable,
    output logic [1:0]                     polySel,
    output logic [bertPkg::DataWidth-1:0]  rateDiv,
    output logic [2:0]                     bertSource,
    output logic [2:0]                     outSource,
    output logic                           injectError,
    output logic                           countClear,
    input  logic                           locked,
    input  logic [bertPkg::CountWidth-1:0] bitCount,
    input  logic [bertPkg::CountWidth-1:0] errCount
);
    import bertPkg::*;

    ctrlWordU             ctrlReg;
    logic [DataWidth-1:0] rateReg;
    logic [DataWidth-1:0] bitHiShadow;
    logic [DataWidth-1:0] errHiShadow;
    logic [DataWidth-1:0] rdMux;

    //**********************************************************
    // Writable registers and write pulses
    //**********************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlReg.raw <= '0;
            rateReg     <= '0;
            injectError <= 1'b0;
            countClear  <= 1'b0;
        end else begin
            injectError <= busWr && (busAddr == AddrInject);
            countClear  <= busWr && (busAddr == AddrStatus);
            if (busWr) begin
                case (busAddr)
                    AddrControl: ctrlReg.raw <= busWrData;
                    AddrRate:    rateReg     <= busWrData;
                    default:     ;
                endcase
            end
        end
    end

    // Field decode
    assign pnEnable   = ctrlReg.fields.pnEnable;
    assign bertEnable = ctrlReg.fields.bertEnable;
    assign polySel    = ctrlReg.fields.polySel;
    assign bertSource = ctrlReg.fields.bertSource;
    assign outSource  = ctrlReg.fields.outSource;
    assign rateDiv    = rateReg;

    // Lo read of the bit count freezes both high halves
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bitHiShadow <= '0;
            errHiShadow <= '0;
        end else if (busRd && (busAddr == AddrBitCountLo)) begin
            bitHiShadow <= bitCount[CountWidth-1:DataWidth];
            errHiShadow <= errCount[CountWidth-1:DataWidth];
        end
    end

    //**********************************************************
    // Read path
    //**********************************************************
    always_comb begin
        case (busAddr)
            AddrVersion:    rdMux = VersionNumber;
            AddrControl:    rdMux = ctrlReg.raw;
            AddrRate:       rdMux = rateReg;
            AddrStatus:     rdMux = {{(DataWidth-1){1'b0}}, locked};
            AddrBitCountLo: rdMux = bitCount[DataWidth-1:0];
            AddrBitCountHi: rdMux = bitHiShadow;
            AddrErrCountLo: rdMux = errCount[DataWidth-1:0];
            AddrErrCountHi: rdMux = errHiShadow;
            default:        rdMux = '0;
        endcase
    end

    // Held until the next read strobe
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busRdData <= '0;
        end else if (busRd) begin
            busRdData <= rdMux;
        end
    end

    // Host issues one access per cycle
    assert property (@(posedge clk) disable iff (!rstN) !(busWr && busRd))
        else $error("Read and write strobes in the same cycle");

endmodule

`default_nettype wire

/* src/bertTop.sv */
`default_nettype none

module bertTop (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          busWr,
    input  logic                          busRd,
    input  logic [bertPkg::AddrWidth-1:0] busAddr,
    input  logic [bertPkg::DataWidth-1:0] busWrData,
    output logic [bertPkg::DataWidth-1:0] busRdData,
    input  logic                          extClkEn,
    input  logic                          extData,
    output logic                          serialClkEn,
    output logic                          serialData,
    output logic                          locked
);
    import bertPkg::*;

    logic                  pnEnable;
    logic                  bertEnable;
    logic [1:0]            polySel;
    logic [DataWidth-1:0]  rateDiv;
    logic [2:0]            bertSource;
    logic [2:0]            outSource;
    logic                  injectError;
    logic                  countClear;
    logic [CountWidth-1:0] bitCount;
    logic [CountWidth-1:0] errCount;
    logic                  pnClkEn;
    logic                  pnBit;
    logic                  bertClkEn;
    logic                  bertData;

    //**********************************************************
    // Host registers
    //**********************************************************
    bertRegs regs_i (
        .clk(clk), .rstN(rstN),
        .busWr(busWr), .busRd(busRd), .busAddr(busAddr),
        .busWrData(busWrData), .busRdData(busRdData),
        .pnEnable(pnEnable), .bertEnable(bertEnable), .polySel(polySel),
        .rateDiv(rateDiv), .bertSource(bertSource), .outSource(outSource),
        .injectError(injectError), .countClear(countClear),
        .locked(locked), .bitCount(bitCount), .errCount(errCount)
    );

    //**********************************************************
    // Datapath
    //**********************************************************
    pnGenerator pnGen_i (
        .clk(clk), .rstN(rstN),
        .pnEnable(pnEnable), .polySel(polySel), .rateDiv(rateDiv),
        .injectError(injectError), .pnClkEn(pnClkEn), .pnBit(pnBit)
    );

    streamRouter router_i (
        .clk(clk), .rstN(rstN),
        .bertSource(bertSource), .outSource(outSource),
        .pnClkEn(pnClkEn), .pnBit(pnBit), .extClkEn(extClkEn), .extData(extData),
        .bertClkEn(bertClkEn), .bertData(bertData),
        .serialClkEn(serialClkEn), .serialData(serialData)
    );

    // Lock also goes to the front panel
    bertChecker checker_i (
        .clk(clk), .rstN(rstN),
        .bertEnable(bertEnable), .bertClkEn(bertClkEn), .bertData(bertData),
        .countClear(countClear), .polySel(polySel),
        .locked(locked), .bitCount(bitCount), .errCount(errCount)
    );

endmodule

`default_nettype wire

/* src/pnGenerator.sv */
`default_nettype none

module pnGenerator (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          pnEnable,
    input  logic [1:0]                    polySel,
    input  logic [bertPkg::DataWidth-1:0] rateDiv,
    input  logic                          injectError,
    output logic                          pnClkEn,
    output logic                          pnBit
);
    import bertPkg::*;

    logic [DataWidth-1:0] rateCnt;
    logic                 bitTick;
    logic [PnMaxLen-1:0]  state;
    logic [PnMaxLen-1:0]  activeMask;
    logic [1:0]           polyPrev;
    logic                 injectPending;
    logic                 feedback;

    // One tick every rateDiv+1 cycles
    assign bitTick = pnEnable && (rateCnt >= rateDiv);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rateCnt <= '0;
            pnClkEn <= 1'b0;
        end else begin
            pnClkEn <= bitTick;
            if (!pnEnable || bitTick) begin
                rateCnt <= '0;
            end else begin
                rateCnt <= rateCnt + 1'b1;
            end
        end
    end

    // Fibonacci register, the new bit enters at [0]
    assign feedback = pnPredict(polySel, state);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state         <= '1;
            polyPrev      <= PolyPn7;
            pnBit         <= 1'b0;
            injectPending <= 1'b0;
        end else begin
            polyPrev <= polySel;
            if (polySel != polyPrev) begin
                state <= '1;
            end else if (bitTick) begin
                state <= {state[PnMaxLen-2:0], feedback};
            end
            // Inversion hits the output only, never the state
            if (bitTick) begin
                pnBit         <= feedback ^ (injectPending | injectError);
                injectPending <= 1'b0;
            end else if (injectError) begin
                injectPending <= 1'b1;
            end
        end
    end

    always_comb begin
        case (polySel)
            PolyPn7:  activeMask = PnMaxLen'((1 << Pn7TapA) - 1);
            PolyPn15: activeMask = PnMaxLen'((1 << Pn15TapA) - 1);
            default:  activeMask = '1;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rstN)
        pnEnable |-> ((state & activeMask) != '0))
        else $error("PN generator state is all zero");

endmodule

`default_nettype wire

/* src/streamRouter.sv */
`default_nettype none

module streamRouter (
    input  logic       clk,
    input  logic       rstN,
    input  logic [2:0] bertSource,
    input  logic [2:0] outSource,
    input  logic       pnClkEn,
    input  logic       pnBit,
    input  logic       extClkEn,
    input  logic       extData,
    output logic       bertClkEn,
    output logic       bertData,
    output logic       serialClkEn,
    output logic       serialData
);
    import bertPkg::*;

    logic [7:0] srcClkEn;
    logic [7:0] srcData;

    // Source table shared by both selections
    always_comb begin
        srcClkEn              = '0;
        srcData               = '0;
        srcClkEn[SrcPnGen]    = pnClkEn;
        srcData[SrcPnGen]     = pnBit;
        srcClkEn[SrcExternal] = extClkEn;
        srcData[SrcExternal]  = extData;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bertClkEn   <= 1'b0;
            bertData    <= 1'b0;
            serialClkEn <= 1'b0;
            serialData  <= 1'b0;
        end else begin
            bertClkEn   <= srcClkEn[bertSource];
            bertData    <= srcData[bertSource];
            serialClkEn <= srcClkEn[outSource];
            serialData  <= srcData[outSource];
        end
    end

endmodule

`default_nettype wire

/* tb/bertTb.sv */
`default_nettype none

module bertTb;
    timeunit 1ns;
    timeprecision 100ps;

    import bertPkg::*;

    // Phase lengths in bits
    localparam int SettleBits    = 160;
    localparam int LockBits      = 200;
    localparam int InjectSpacing = 100;
    localparam int RunBits       = 300;
    localparam int MarginCycles  = 2000;
    localparam int NumRows       = 7;

    typedef struct {
        string      name;
        logic [1:0] polySel;
        int         rateDiv;
        logic [2:0] bertSource;
        logic [2:0] outSource;
        int         injects;
        int         tapA;
        int         tapB;
        logic       expLock;
        int         expErrors;
    } testRow;

    testRow rows [NumRows] = '{
        '{"pn7Loop",    PolyPn7,  0, SrcPnGen,    SrcPnGen,    0,  7,  6, 1'b1, 0},
        '{"pn15Loop",   PolyPn15, 1, SrcPnGen,    SrcPnGen,    0, 15, 14, 1'b1, 0},
        '{"extRandom",  PolyPn7,  0, SrcExternal, SrcExternal, 0,  7,  6, 1'b0, 0},
        '{"extPn23Out", PolyPn23, 1, SrcExternal, SrcPnGen,    0, 23, 18, 1'b0, 0},
        '{"pn23Loop",   PolyPn23, 2, SrcPnGen,    SrcPnGen,    0, 23, 18, 1'b1, 0},
        '{"pn15Inject", PolyPn15, 0, SrcPnGen,    SrcExternal, 3, 15, 14, 1'b1, 9},
        '{"pn23Inject", PolyPn23, 3, SrcPnGen,    SrcExternal, 2, 23, 18, 1'b1, 6}
    };

    logic                 clk;
    logic                 rstN;
    logic                 busWr;
    logic                 busRd;
    logic [AddrWidth-1:0] busAddr;
    logic [DataWidth-1:0] busWrData;
    logic [DataWidth-1:0] busRdData;
    logic                 extClkEn = 1'b0;
    logic                 extData  = 1'b0;
    logic                 serialClkEn;
    logic                 serialData;
    logic                 locked;

    int          errorCount   = 0;
    int          checkCount   = 0;
    int          cycleCount   = 0;
    int          timeoutLimit = 0;
    logic [31:0] lfsrState    = 32'd95096;

    // Serial output monitor, newest bit in serialHist[0]
    logic        monitorOn   = 1'b0;
    logic        monitorExt  = 1'b0;
    string       curName     = "reset";
    int          curTapA     = 7;
    int          curTapB     = 6;
    int          curGap      = 1;
    int          sinceStrobe = 0;
    logic [22:0] serialHist  = '0;
    int          serialSeen  = 0;
    logic        prevExtData = 1'b0;

    tbClock clock_i (.clk(clk), .rstN(rstN));

    bertTop dut_i (
        .clk(clk), .rstN(rstN),
        .busWr(busWr), .busRd(busRd), .busAddr(busAddr),
        .busWrData(busWrData), .busRdData(busRdData),
        .extClkEn(extClkEn), .extData(extData),
        .serialClkEn(serialClkEn), .serialData(serialData),
        .locked(locked)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rowCycles(input testRow r);
        return (SettleBits + LockBits + r.injects * InjectSpacing + RunBits) * (r.rateDiv + 1);
    endfunction

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        checkCount++;
        assert (expected === actual) else begin
            errorCount++;
            $display("FAIL %s %s: expected %0d, actual %0d", testName, what, expected, actual);
        end
    endtask

    task automatic writeReg(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
        @(posedge clk);
        busWr     <= 1'b1;
        busAddr   <= addr;
        busWrData <= data;
        @(posedge clk);
        busWr <= 1'b0;
    endtask

    task automatic readReg(input logic [AddrWidth-1:0] addr, output logic [DataWidth-1:0] data);
        @(posedge clk);
        busRd   <= 1'b1;
        busAddr <= addr;
        @(posedge clk);
        busRd <= 1'b0;
        @(negedge clk);
        data = busRdData;
    endtask

    // Lo read of the bit count freezes both high halves
    task automatic readCounters(output logic [31:0] bits, output logic [31:0] errs);
        logic [15:0] lo;
        logic [15:0] hi;
        readReg(AddrBitCountLo, lo);
        readReg(AddrBitCountHi, hi);
        bits = {hi, lo};
        readReg(AddrErrCountLo, lo);
        readReg(AddrErrCountHi, hi);
        errs = {hi, lo};
    endtask

    task automatic waitBits(input int bits, input int rate);
        repeat (bits * (rate + 1)) @(posedge clk);
    endtask

    task automatic waitForLock(input testRow r);
        int budget;
        budget = LockBits * (r.rateDiv + 1);
        @(negedge clk);
        while (budget > 0 && locked !== 1'b1) begin
            @(negedge clk);
            budget--;
        end
        checkCount++;
        assert (locked === 1'b1) else begin
            errorCount++;
            $display("%s: the BERT did not lock within %0d bits", r.name, LockBits);
        end
    endtask

    //**********************************************************
    // One table row
    //**********************************************************
    task automatic runRow(input testRow r);
        logic [15:0] ctrl;
        logic [15:0] status;
        logic [31:0] bits;
        logic [31:0] errs;
        ctrl = {5'b0, r.outSource, 1'b0, r.bertSource, r.polySel, 2'b11};
        monitorOn = 1'b0;
        writeReg(AddrRate, 16'(r.rateDiv));
        writeReg(AddrControl, ctrl);
        // Let the old stream drain out of the checker
        waitBits(SettleBits, r.rateDiv);
        if (r.expLock) begin
            waitForLock(r);
        end
        writeReg(AddrStatus, '0);
        curName     = r.name;
        curTapA     = r.tapA;
        curTapB     = r.tapB;
        curGap      = (r.outSource == SrcExternal) ? 1 : r.rateDiv + 1;
        sinceStrobe = 0;
        serialSeen  = 0;
        monitorExt  = (r.outSource == SrcExternal);
        monitorOn   = 1'b1;
        repeat (r.injects) begin
            writeReg(AddrInject, '0);
            waitBits(InjectSpacing, r.rateDiv);
        end
        waitBits(RunBits, r.rateDiv);
        monitorOn = 1'b0;
        readReg(AddrStatus, status);
        readCounters(bits, errs);
        checkValue(r.name, "status", 32'(r.expLock), 32'(status));
        checkValue(r.name, "locked", 32'(r.expLock), 32'(locked));
        checkValue(r.name, "error count", r.expErrors, errs);
        checkCount++;
        assert (serialSeen >= RunBits) else begin
            errorCount++;
            $display("%s: only %0d serial output strobes were seen", r.name, serialSeen);
        end
        if (r.expLock) begin
            checkCount++;
            assert (bits != 0) else begin
                errorCount++;
                $display("%s: the bit count stayed at zero while locked", r.name);
            end
        end else begin
            checkValue(r.name, "bit count", 0, bits);
        end
    endtask

    // External stream, one new bit per cycle
    always @(posedge clk) begin
        if (rstN) begin
            lfsrState = nextRandom(lfsrState);
            extClkEn <= 1'b1;
            extData  <= lfsrState[0];
        end
    end

    always @(negedge clk) begin
        logic expectedBit;
        if (monitorOn) begin
            sinceStrobe++;
        end
        if (monitorOn && serialClkEn) begin
            if (serialSeen > 0) begin
                checkValue(curName, "serialClkEn spacing", curGap, sinceStrobe);
            end
            sinceStrobe = 0;
            if (monitorExt) begin
                checkValue(curName, "serialData", 32'(prevExtData), 32'(serialData));
            end else begin
                if (serialSeen >= curTapA) begin
                    expectedBit = serialHist[curTapA-1] ^ serialHist[curTapB-1];
                    checkValue(curName, "serialData", 32'(expectedBit), 32'(serialData));
                end
                serialHist = {serialHist[21:0], serialData};
            end
            serialSeen++;
        end
        prevExtData = extData;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout after %0d cycles, errors so far: %0d", cycleCount, errorCount);
            $display("Simulation failed");
            $finish;
        end
    end

    //**********************************************************
    // Main sequence
    //**********************************************************
    initial begin
        logic [15:0] rd;
        logic [31:0] bits;
        logic [31:0] errs;
        busWr     <= 1'b0;
        busRd     <= 1'b0;
        busAddr   <= '0;
        busWrData <= '0;
        for (int i = 0; i < NumRows; i++) begin
            timeoutLimit += rowCycles(rows[i]);
        end
        timeoutLimit += MarginCycles;
        wait (rstN === 1'b1);

        checkValue("reset", "locked", 0, 32'(locked));
        readReg(AddrVersion, rd);
        checkValue("reset", "version", 428, 32'(rd));
        readReg(AddrControl, rd);
        checkValue("reset", "control", 0, 32'(rd));
        readReg(AddrStatus, rd);
        checkValue("reset", "status", 0, 32'(rd));
        readCounters(bits, errs);
        checkValue("reset", "bit count", 0, bits);
        checkValue("reset", "error count", 0, errs);

        // Readback with both enables off
        writeReg(AddrControl, 16'h0734);
        readReg(AddrControl, rd);
        checkValue("regAccess", "control", 32'h0734, 32'(rd));
        writeReg(AddrRate, 16'h1234);
        readReg(AddrRate, rd);
        checkValue("regAccess", "rate", 32'h1234, 32'(rd));
        writeReg(AddrVersion, 16'hffff);
        readReg(AddrVersion, rd);
        checkValue("regAccess", "version", 428, 32'(rd));

        for (int i = 0; i < NumRows; i++) begin
            runRow(rows[i]);
        end

        // BERT halted so the counters hold still
        writeReg(AddrControl, 16'h0001);
        readCounters(bits, errs);
        checkValue("countClear", "error count before clear", rows[NumRows-1].expErrors, errs);
        writeReg(AddrStatus, '0);
        readCounters(bits, errs);
        checkValue("countClear", "bit count", 0, bits);
        checkValue("countClear", "error count", 0, errs);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/tbClock.sv */
`default_nettype none

module tbClock (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HalfPeriod  = 4;
    localparam int ResetCycles = 8;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire
